/* verilog/fx3_pkg.sv */
`default_nettype none

package fx3_pkg;

    // one word of the slave-fifo data bus
    typedef logic [15:0] fx3_word_t;

    // slave-fifo address pins, A1 then A0
    typedef logic [1:0] fx3_addr_t;

    // master phases
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        STREAM_OUT = 2'd1,
        TURNAROUND = 2'd2,
        STREAM_IN  = 2'd3
    } fx3_state_t;

    // read socket, chip to fpga
    localparam fx3_addr_t ADDR_STREAM_OUT = 2'b11;
    // write socket, fpga to chip
    localparam fx3_addr_t ADDR_STREAM_IN  = 2'b00;
    // parked address while idle or turning around
    localparam fx3_addr_t ADDR_PARK       = 2'b10;

    // status byte codes on the leds
    // idle also shows flagc on bit 6 and flagd on bit 7
    localparam logic [7:0] LED_IDLE = 8'h00;
    localparam logic [7:0] LED_OUT  = 8'h03;
    localparam logic [7:0] LED_TURN = 8'h0F;
    localparam logic [7:0] LED_IN   = 8'h07;

endpackage

`default_nettype wire

/* verilog/loop_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 10
) (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               push_i,
    input  fx3_pkg::fx3_word_t push_data_i,
    input  logic               pop_i,
    output fx3_pkg::fx3_word_t pop_data_o,
    output logic               empty_o
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    fx3_pkg::fx3_word_t mem [DEPTH];

    // extra msb tells a full ring from an empty one
    logic [FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;

    assign empty_o = (wr_ptr == rd_ptr);

    // head word is visible as soon as it is written
    assign pop_data_o = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

    // storage
    always_ff @(posedge usb_clk) begin
        if (push_i) begin
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= push_data_i;
        end
    end

    // pointers
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // pop only when there is something to pop
            if (pop_i && !empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fx3_pin_drv.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_pin_drv (
    input  logic                usb_clk,
    input  logic                reset_,
    input  fx3_pkg::fx3_state_t state_i,
    input  logic                rd_req_i,
    input  logic                wr_req_i,
    input  fx3_pkg::fx3_word_t  wr_data_i,
    input  fx3_pkg::fx3_word_t  fdata_i,
    output logic                slcs_o,
    output logic                sloe_o,
    output logic                slrd_o,
    output logic                slwr_o,
    output logic                pktend_o,
    output fx3_pkg::fx3_addr_t  addr_o,
    output fx3_pkg::fx3_word_t  fdata_o,
    output logic                fdata_oe_o,
    output fx3_pkg::fx3_word_t  cap_data_o
);

    logic               cs_n;
    logic               oe_n;
    fx3_pkg::fx3_addr_t addr_d;

    // phase to select, output enable and socket address
    always_comb begin
        cs_n   = 1'b0;
        oe_n   = 1'b1;
        addr_d = fx3_pkg::ADDR_PARK;
        case (state_i)
            fx3_pkg::IDLE: begin
                cs_n = 1'b1;
            end
            fx3_pkg::STREAM_OUT: begin
                // chip drives the bus for the whole read phase
                oe_n   = 1'b0;
                addr_d = fx3_pkg::ADDR_STREAM_OUT;
            end
            fx3_pkg::STREAM_IN: begin
                addr_d = fx3_pkg::ADDR_STREAM_IN;
            end
            default: begin
                // turnaround keeps the chip selected but parked
                addr_d = fx3_pkg::ADDR_PARK;
            end
        endcase
    end

    // control pins, all strobes active low
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_o     <= 1'b1;
            sloe_o     <= 1'b1;
            slrd_o     <= 1'b1;
            slwr_o     <= 1'b1;
            pktend_o   <= 1'b1;
            addr_o     <= fx3_pkg::ADDR_PARK;
            fdata_oe_o <= 1'b0;
        end else begin
            slcs_o     <= cs_n;
            sloe_o     <= oe_n;
            slrd_o     <= !rd_req_i;
            slwr_o     <= !wr_req_i;
            // no short packets, pktend never asserted
            pktend_o   <= 1'b1;
            addr_o     <= addr_d;
            // drive the bus only in write cycles
            fdata_oe_o <= wr_req_i;
        end
    end

    // data bus in both directions
    always_ff @(posedge usb_clk) begin
        fdata_o    <= wr_data_i;
        cap_data_o <= fdata_i;
    end

endmodule

`default_nettype wire

/* verilog/fx3_stream_in_wr.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_stream_in_wr #(
    parameter int BURST_WORDS = 512
) (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               start_i,
    input  logic               flaga_s_i,
    input  logic               flagb_s_i,
    input  logic               empty_i,
    input  fx3_pkg::fx3_word_t pop_data_i,
    output logic               pop_o,
    output logic               wr_req_o,
    output fx3_pkg::fx3_word_t wr_data_o,
    output logic               done_o
);

    localparam int CNT_W = $clog2(BURST_WORDS + 1);

    logic             armed;
    // writes issued in this burst
    logic [CNT_W-1:0] wr_cnt;
    logic             last_wr;

    // chip has room and a word is waiting
    assign wr_req_o = armed && flaga_s_i && flagb_s_i && !empty_i;
    // every write consumes the fifo head
    assign pop_o     = wr_req_o;
    assign wr_data_o = pop_data_i;

    assign last_wr = wr_req_o && (wr_cnt == CNT_W'(BURST_WORDS - 1));

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            armed  <= 1'b0;
            wr_cnt <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= last_wr;
            if (start_i) begin
                armed  <= 1'b1;
                wr_cnt <= '0;
            end else if (last_wr) begin
                // burst complete, wait for the next start
                armed  <= 1'b0;
                wr_cnt <= '0;
            end else if (wr_req_o) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fx3_stream_out_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_stream_out_rd #(
    parameter int BURST_WORDS = 512,
    parameter int RD_LATENCY  = 2
) (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               start_i,
    input  fx3_pkg::fx3_word_t cap_data_i,
    output logic               rd_req_o,
    output logic               push_o,
    output fx3_pkg::fx3_word_t push_data_o,
    output logic               done_o
);

    // output register, chip latency, input register
    localparam int PIPE_LEN = RD_LATENCY + 2;
    localparam int CNT_W    = $clog2(BURST_WORDS + 1);

    // strobes still to issue after the first one
    logic [CNT_W-1:0]    rd_left;
    // one bit per strobe in flight
    logic [PIPE_LEN-1:0] rd_pipe;

    // first strobe goes out with start, so slrd_o follows one cycle later
    assign rd_req_o = start_i || (rd_left != '0);

    // word in cap_data belongs to the strobe leaving the pipe
    assign push_o      = rd_pipe[PIPE_LEN-1];
    assign push_data_o = cap_data_i;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_left <= '0;
            rd_pipe <= '0;
            done_o  <= 1'b0;
        end else begin
            if (start_i) begin
                rd_left <= CNT_W'(BURST_WORDS - 1);
            end else if (rd_left != '0) begin
                rd_left <= rd_left - 1'b1;
            end
            rd_pipe <= {rd_pipe[PIPE_LEN-2:0], rd_req_o};
            // last push with nothing behind it
            done_o  <= push_o && (rd_pipe[PIPE_LEN-2:0] == '0) && !rd_req_o;
        end
    end

endmodule

`default_nettype wire

/* verilog/fx3_mode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_mode_ctrl (
    input  logic                usb_clk,
    input  logic                reset_,
    input  logic                flaga_i,
    input  logic                flagb_i,
    input  logic                flagc_i,
    input  logic                flagd_i,
    input  logic                rd_done_i,
    input  logic                wr_done_i,
    output fx3_pkg::fx3_state_t state_o,
    output logic                start_rd_o,
    output logic                start_wr_o,
    output logic                flaga_s_o,
    output logic                flagb_s_o,
    output logic [7:0]          led_o
);

    // synchronised read flags, only used here
    logic                flagc_s;
    logic                flagd_s;
    // second cycle of the turnaround
    logic                turn_cnt;
    fx3_pkg::fx3_state_t state_d;

    // one register stage on every flag from the chip
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            flaga_s_o <= 1'b0;
            flagb_s_o <= 1'b0;
            flagc_s   <= 1'b0;
            flagd_s   <= 1'b0;
        end else begin
            flaga_s_o <= flaga_i;
            flagb_s_o <= flagb_i;
            flagc_s   <= flagc_i;
            flagd_s   <= flagd_i;
        end
    end

    // next phase
    always_comb begin
        state_d = state_o;
        case (state_o)
            fx3_pkg::IDLE: begin
                // both read buffers full on the chip
                if (flagc_s && flagd_s) begin
                    state_d = fx3_pkg::STREAM_OUT;
                end
            end
            fx3_pkg::STREAM_OUT: begin
                if (rd_done_i) begin
                    state_d = fx3_pkg::TURNAROUND;
                end
            end
            fx3_pkg::TURNAROUND: begin
                if (turn_cnt) begin
                    state_d = fx3_pkg::STREAM_IN;
                end
            end
            fx3_pkg::STREAM_IN: begin
                if (wr_done_i) begin
                    state_d = fx3_pkg::IDLE;
                end
            end
            default: begin
                state_d = fx3_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            state_o    <= fx3_pkg::IDLE;
            start_rd_o <= 1'b0;
            start_wr_o <= 1'b0;
            turn_cnt   <= 1'b0;
        end else begin
            state_o    <= state_d;
            // start pulses line up with the first cycle of the new phase
            start_rd_o <= (state_o == fx3_pkg::IDLE) && (state_d == fx3_pkg::STREAM_OUT);
            start_wr_o <= (state_o == fx3_pkg::TURNAROUND) && (state_d == fx3_pkg::STREAM_IN);
            // toggles once, so turnaround lasts two cycles
            turn_cnt   <= (state_o == fx3_pkg::TURNAROUND) && !turn_cnt;
        end
    end

    // status byte, one cycle behind the phase
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            led_o <= fx3_pkg::LED_IDLE;
        end else begin
            case (state_o)
                fx3_pkg::IDLE:       led_o <= fx3_pkg::LED_IDLE | {flagd_s, flagc_s, 6'b0};
                fx3_pkg::STREAM_OUT: led_o <= fx3_pkg::LED_OUT;
                fx3_pkg::TURNAROUND: led_o <= fx3_pkg::LED_TURN;
                default:             led_o <= fx3_pkg::LED_IN;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fx3_loopback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_loopback_top #(
    parameter int BURST_WORDS     = 512,
    parameter int RD_LATENCY      = 2,
    parameter int FIFO_DEPTH_LOG2 = 10
) (
    input  logic              usb_clk,
    input  logic              reset_,
    input  logic              flaga_i,
    input  logic              flagb_i,
    input  logic              flagc_i,
    input  logic              flagd_i,
    input  fx3_pkg::fx3_word_t fdata_i,
    output logic              slcs_o,
    output logic              sloe_o,
    output logic              slrd_o,
    output logic              slwr_o,
    output logic              pktend_o,
    output fx3_pkg::fx3_addr_t addr_o,
    output fx3_pkg::fx3_word_t fdata_o,
    output logic              fdata_oe_o,
    output logic [7:0]        led_o
);

    // phase and handshakes between the controller and the two movers
    fx3_pkg::fx3_state_t state;
    logic                start_rd;
    logic                start_wr;
    logic                rd_done;
    logic                wr_done;
    logic                flaga_s;
    logic                flagb_s;

    // read side into the fifo
    logic                rd_req;
    fx3_pkg::fx3_word_t  cap_data;
    logic                push;
    fx3_pkg::fx3_word_t  push_data;

    // fifo out to the write side
    logic                pop;
    fx3_pkg::fx3_word_t  pop_data;
    logic                empty;
    logic                wr_req;
    fx3_pkg::fx3_word_t  wr_data;

    fx3_mode_ctrl u_mode_ctrl (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .flaga_i    (flaga_i),
        .flagb_i    (flagb_i),
        .flagc_i    (flagc_i),
        .flagd_i    (flagd_i),
        .rd_done_i  (rd_done),
        .wr_done_i  (wr_done),
        .state_o    (state),
        .start_rd_o (start_rd),
        .start_wr_o (start_wr),
        .flaga_s_o  (flaga_s),
        .flagb_s_o  (flagb_s),
        .led_o      (led_o)
    );

    fx3_stream_out_rd #(
        .BURST_WORDS (BURST_WORDS),
        .RD_LATENCY  (RD_LATENCY)
    ) u_stream_out_rd (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .start_i     (start_rd),
        .cap_data_i  (cap_data),
        .rd_req_o    (rd_req),
        .push_o      (push),
        .push_data_o (push_data),
        .done_o      (rd_done)
    );

    loop_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_loop_fifo (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (empty)
    );

    fx3_stream_in_wr #(
        .BURST_WORDS (BURST_WORDS)
    ) u_stream_in_wr (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .start_i    (start_wr),
        .flaga_s_i  (flaga_s),
        .flagb_s_i  (flagb_s),
        .empty_i    (empty),
        .pop_data_i (pop_data),
        .pop_o      (pop),
        .wr_req_o   (wr_req),
        .wr_data_o  (wr_data),
        .done_o     (wr_done)
    );

    fx3_pin_drv u_pin_drv (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .state_i    (state),
        .rd_req_i   (rd_req),
        .wr_req_i   (wr_req),
        .wr_data_i  (wr_data),
        .fdata_i    (fdata_i),
        .slcs_o     (slcs_o),
        .sloe_o     (sloe_o),
        .slrd_o     (slrd_o),
        .slwr_o     (slwr_o),
        .pktend_o   (pktend_o),
        .addr_o     (addr_o),
        .fdata_o    (fdata_o),
        .fdata_oe_o (fdata_oe_o),
        .cap_data_o (cap_data)
    );

endmodule

`default_nettype wire

/* verification/fx3_host_model.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_host_model #(
    parameter int RD_LATENCY = 2,
    parameter int BUF_WORDS  = 16
) (
    input  logic                         usb_clk,
    input  logic                         reset_,
    input  logic                         src_we_i,
    input  logic [$clog2(BUF_WORDS)-1:0] src_idx_i,
    input  fx3_pkg::fx3_word_t           src_word_i,
    input  logic                         row_start_i,
    input  logic [15:0]                  stall_at_i,
    input  logic [15:0]                  stall_len_i,
    input  logic                         slcs_i,
    input  logic                         slrd_i,
    input  logic                         slwr_i,
    input  fx3_pkg::fx3_addr_t           addr_i,
    input  fx3_pkg::fx3_word_t           wdata_i,
    input  logic                         wdata_oe_i,
    output fx3_pkg::fx3_word_t           fdata_o,
    output logic                         flagb_o,
    output logic                         wr_ev_o,
    output fx3_pkg::fx3_word_t           wr_word_o,
    output fx3_pkg::fx3_addr_t           wr_addr_o,
    output logic                         wr_oe_o,
    output logic [7:0]                   over_cnt_o
);

    localparam int IDX_W = $clog2(BUF_WORDS);

    // words the chip hands out on reads
    fx3_pkg::fx3_word_t src_mem [BUF_WORDS];
    // read words on their way to the bus, one stage short of the latency
    fx3_pkg::fx3_word_t lat_q [RD_LATENCY-1];
    fx3_pkg::fx3_word_t fdata_q = '0;
    logic               flagb_q = 1'b1;
    logic [IDX_W-1:0]   rd_idx;
    logic [15:0]        wr_cnt;
    logic [15:0]        stall_left;
    logic               stall_armed;
    // words taken since flagb went low
    logic [7:0]         late_cnt;
    logic               rd_hit;
    logic               wr_hit;

    // chip samples the strobes on the rising edge
    assign rd_hit  = !slcs_i && !slrd_i;
    assign wr_hit  = !slcs_i && !slwr_i;
    assign fdata_o = fdata_q;
    assign flagb_o = flagb_q;

    always @(posedge usb_clk) begin
        if (src_we_i) begin
            src_mem[src_idx_i] <= src_word_i;
        end
    end

    always @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            for (int i = 0; i < RD_LATENCY - 1; i++) begin
                lat_q[i] <= '0;
            end
            fdata_q     <= '0;
            flagb_q     <= 1'b1;
            rd_idx      <= '0;
            wr_cnt      <= '0;
            stall_left  <= '0;
            stall_armed <= 1'b0;
            late_cnt    <= '0;
            over_cnt_o  <= '0;
            wr_ev_o     <= 1'b0;
            wr_word_o   <= '0;
            wr_addr_o   <= '0;
            wr_oe_o     <= 1'b0;
        end else begin
            // write record, one event per accepted word
            wr_ev_o   <= wr_hit;
            wr_word_o <= wdata_i;
            wr_addr_o <= addr_i;
            wr_oe_o   <= wdata_oe_i;
            // marker word on idle slots makes a misaligned push visible
            lat_q[0] <= rd_hit ? src_mem[rd_idx] : 16'hdead;
            for (int i = 1; i < RD_LATENCY - 1; i++) begin
                lat_q[i] <= lat_q[i-1];
            end
            fdata_q <= lat_q[RD_LATENCY-2];
            if (row_start_i) begin
                rd_idx      <= '0;
                wr_cnt      <= '0;
                stall_left  <= '0;
                stall_armed <= 1'b1;
                late_cnt    <= '0;
                over_cnt_o  <= '0;
                flagb_q     <= 1'b1;
            end else begin
                if (rd_hit) begin
                    rd_idx <= rd_idx + 1'b1;
                end
                if (wr_hit) begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
                if (!flagb_q) begin
                    // up to 4 words may still land after the flag drops
                    if (wr_hit) begin
                        late_cnt <= late_cnt + 1'b1;
                        if (late_cnt >= 8'd4) begin
                            over_cnt_o <= over_cnt_o + 1'b1;
                        end
                    end
                    stall_left <= stall_left - 1'b1;
                    if (stall_left == 16'd1) begin
                        flagb_q <= 1'b1;
                    end
                end else if (stall_armed && (stall_len_i != '0) && wr_hit
                             && (wr_cnt == stall_at_i)) begin
                    // buffer full right after word stall_at
                    flagb_q     <= 1'b0;
                    stall_left  <= stall_len_i;
                    stall_armed <= 1'b0;
                    late_cnt    <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_fx3_loopback.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fx3_loopback;

    localparam int BW          = 16;
    localparam int RD_LAT      = 2;
    localparam int IDX_W       = $clog2(BW);
    localparam int NUM_ROWS    = 4;
    localparam int CYCLE_LIMIT = NUM_ROWS * (4 * BW + 100);

    logic               usb_clk;
    logic               reset_;
    logic               flaga;
    logic               flagb;
    logic               flagc;
    logic               flagd;
    fx3_pkg::fx3_word_t fdata_in;
    logic               slcs_o;
    logic               sloe_o;
    logic               slrd_o;
    logic               slwr_o;
    logic               pktend_o;
    fx3_pkg::fx3_addr_t addr_o;
    fx3_pkg::fx3_word_t fdata_o;
    logic               fdata_oe_o;
    logic [7:0]         led_o;

    // chip model controls and write record
    logic               src_we;
    logic [IDX_W-1:0]   src_idx;
    fx3_pkg::fx3_word_t src_word;
    logic               row_start;
    logic [15:0]        stall_at;
    logic [15:0]        stall_len;
    logic               wr_ev;
    fx3_pkg::fx3_word_t wr_word;
    fx3_pkg::fx3_addr_t wr_addr;
    logic               wr_oe;
    logic [7:0]         over_cnt;

    // stimulus table, pattern 0 means random words
    string              row_name      [NUM_ROWS] = '{"single_burst", "stall_early",
                                                     "stall_late", "long_stall"};
    fx3_pkg::fx3_word_t row_pat       [NUM_ROWS] = '{16'h0000, 16'h0000, 16'ha5c3, 16'h0000};
    int                 row_stall_at  [NUM_ROWS] = '{0, 2, 13, 7};
    int                 row_stall_len [NUM_ROWS] = '{0, 6, 20, 40};
    int                 row_words     [NUM_ROWS] = '{16, 16, 16, 16};

    integer seed;
    int     errors;
    int     checks;
    int     cyc;
    // bus monitor state
    int     rd_low_cnt;
    int     rd_runs;
    int     rd_first;
    int     rise_cyc;
    int     rd_bad;
    int     wr_bad;
    int     pkt_bad;
    logic   rd_prev = 1'b1;
    logic   cd_prev = 1'b0;
    fx3_pkg::fx3_word_t exp_q [$];
    fx3_pkg::fx3_word_t got_q [$];

    fx3_loopback_top #(
        .BURST_WORDS (BW),
        .RD_LATENCY  (RD_LAT)
    ) uut (
        .usb_clk    (usb_clk),
        .reset_     (reset_),
        .flaga_i    (flaga),
        .flagb_i    (flagb),
        .flagc_i    (flagc),
        .flagd_i    (flagd),
        .fdata_i    (fdata_in),
        .slcs_o     (slcs_o),
        .sloe_o     (sloe_o),
        .slrd_o     (slrd_o),
        .slwr_o     (slwr_o),
        .pktend_o   (pktend_o),
        .addr_o     (addr_o),
        .fdata_o    (fdata_o),
        .fdata_oe_o (fdata_oe_o),
        .led_o      (led_o)
    );

    fx3_host_model #(
        .RD_LATENCY (RD_LAT),
        .BUF_WORDS  (BW)
    ) host (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .src_we_i    (src_we),
        .src_idx_i   (src_idx),
        .src_word_i  (src_word),
        .row_start_i (row_start),
        .stall_at_i  (stall_at),
        .stall_len_i (stall_len),
        .slcs_i      (slcs_o),
        .slrd_i      (slrd_o),
        .slwr_i      (slwr_o),
        .addr_i      (addr_o),
        .wdata_i     (fdata_o),
        .wdata_oe_i  (fdata_oe_o),
        .fdata_o     (fdata_in),
        .flagb_o     (flagb),
        .wr_ev_o     (wr_ev),
        .wr_word_o   (wr_word),
        .wr_addr_o   (wr_addr),
        .wr_oe_o     (wr_oe),
        .over_cnt_o  (over_cnt)
    );

    always #20 usb_clk = ~usb_clk;

    // cycle count and run limit
    always @(posedge usb_clk) begin
        cyc = cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT did not finish its bursts", cyc);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // pins sampled mid-cycle, away from the clock edge
    always @(negedge usb_clk) begin
        if (!slrd_o) begin
            rd_low_cnt = rd_low_cnt + 1;
            if (rd_prev) begin
                rd_runs  = rd_runs + 1;
                rd_first = cyc;
            end
            if (addr_o !== fx3_pkg::ADDR_STREAM_OUT || slcs_o || sloe_o) begin
                rd_bad = rd_bad + 1;
            end
        end
        rd_prev = slrd_o;
        if (flagc && flagd && !cd_prev) begin
            rise_cyc = cyc;
        end
        cd_prev = flagc && flagd;
        if (wr_ev) begin
            got_q.push_back(wr_word);
            if (wr_addr !== fx3_pkg::ADDR_STREAM_IN || !wr_oe) begin
                wr_bad = wr_bad + 1;
            end
        end
        if (!pktend_o) begin
            pkt_bad = pkt_bad + 1;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_reset_pins();
        @(negedge usb_clk);
        compare_value("reset slcs_o", 1, 32'(slcs_o));
        compare_value("reset sloe_o", 1, 32'(sloe_o));
        compare_value("reset slrd_o", 1, 32'(slrd_o));
        compare_value("reset slwr_o", 1, 32'(slwr_o));
        compare_value("reset pktend_o", 1, 32'(pktend_o));
        compare_value("reset fdata_oe_o", 0, 32'(fdata_oe_o));
        compare_value("reset addr_o", 32'(fx3_pkg::ADDR_PARK), 32'(addr_o));
        compare_value("reset led_o", 32'(fx3_pkg::LED_IDLE), 32'(led_o));
    endtask

    // chip must stay unselected for a number of cycles
    task automatic hold_idle(input string tag, input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge usb_clk);
            compare_value({tag, " slcs_o"}, 1, 32'(slcs_o));
            compare_value({tag, " slrd_o"}, 1, 32'(slrd_o));
            compare_value({tag, " slwr_o"}, 1, 32'(slwr_o));
        end
    endtask

    task automatic check_one_flag();
        @(posedge usb_clk);
        flagc <= 1'b1;
        hold_idle("flagc only", 12);
        // idle status shows flagc on bit 6
        compare_value("flagc only led_o", 32'h40, 32'(led_o));
        @(posedge usb_clk);
        flagc <= 1'b0;
        flagd <= 1'b1;
        hold_idle("flagd only", 12);
        // and flagd on bit 7
        compare_value("flagd only led_o", 32'h80, 32'(led_o));
        @(posedge usb_clk);
        flagd <= 1'b0;
        hold_idle("flags low", 4);
    endtask

    task automatic run_row(input int r);
        fx3_pkg::fx3_word_t w;
        integer             rnd;
        int                 i;
        int                 n;
        // fresh chip state and stall point for this row
        @(posedge usb_clk);
        row_start <= 1'b1;
        stall_at  <= 16'(row_stall_at[r]);
        stall_len <= 16'(row_stall_len[r]);
        @(posedge usb_clk);
        row_start <= 1'b0;
        exp_q.delete();
        got_q.delete();
        rd_low_cnt = 0;
        rd_runs    = 0;
        rd_bad     = 0;
        wr_bad     = 0;
        // fill the chip source buffer
        for (i = 0; i < BW; i++) begin
            if (row_pat[r] == 16'h0000) begin
                rnd = $random(seed);
                w   = rnd[15:0];
            end else begin
                w = row_pat[r] ^ {i[7:0], i[7:0]};
            end
            exp_q.push_back(w);
            src_we   <= 1'b1;
            src_idx  <= IDX_W'(i);
            src_word <= w;
            @(posedge usb_clk);
        end
        src_we <= 1'b0;
        // both read buffers full
        flagc <= 1'b1;
        flagd <= 1'b1;
        while (slcs_o) @(negedge usb_clk);
        @(posedge usb_clk);
        flagc <= 1'b0;
        flagd <= 1'b0;
        // write phase, then chip deselected again
        while (led_o != fx3_pkg::LED_IN) @(negedge usb_clk);
        while (!slcs_o) @(negedge usb_clk);
        repeat (2) @(negedge usb_clk);
        compare_value({row_name[r], " read strobes"}, BW, rd_low_cnt);
        compare_value({row_name[r], " read bursts"}, 1, rd_runs);
        compare_value({row_name[r], " read start delay"}, 3, rd_first - rise_cyc);
        compare_value({row_name[r], " read pin errors"}, 0, rd_bad);
        compare_value({row_name[r], " word count"}, row_words[r], got_q.size());
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (i = 0; i < n; i++) begin
            compare_value($sformatf("%s word %0d", row_name[r], i),
                          32'(exp_q[i]), 32'(got_q[i]));
        end
        compare_value({row_name[r], " write pin errors"}, 0, wr_bad);
        compare_value({row_name[r], " words past flagb"}, 0, 32'(over_cnt));
        compare_value({row_name[r], " idle slcs_o"}, 1, 32'(slcs_o));
        compare_value({row_name[r], " idle led_o"}, 32'(fx3_pkg::LED_IDLE), 32'(led_o));
    endtask

    initial begin
        int r;
        usb_clk   = 1'b0;
        reset_    = 1'b0;
        flaga     = 1'b0;
        flagc     = 1'b0;
        flagd     = 1'b0;
        src_we    = 1'b0;
        src_idx   = '0;
        src_word  = '0;
        row_start = 1'b0;
        stall_at  = '0;
        stall_len = '0;
        seed      = 32'h7024_ee0f;
        errors    = 0;
        checks    = 0;
        cyc       = 0;
        repeat (5) @(posedge usb_clk);
        reset_ <= 1'b1;
        flaga  <= 1'b1;
        check_reset_pins();
        check_one_flag();
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        compare_value("pktend_o low cycles", 0, pkt_bad);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
verilog/fx3_pkg.sv
verilog/loop_fifo.sv
verilog/fx3_pin_drv.sv
verilog/fx3_stream_in_wr.sv
verilog/fx3_stream_out_rd.sv
verilog/fx3_mode_ctrl.sv
verilog/fx3_loopback_top.sv
verification/fx3_host_model.sv
verification/tb_fx3_loopback.sv

/* run.sh */
#!/bin/sh
# build the loopback testbench with verilator, run it, then look for the pass line
verilator --binary --timing --top-module tb_fx3_loopback -f list.f -o tb_fx3_loopback \
    && ./obj_dir/tb_fx3_loopback | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
